/* Makefile */
VERILATOR ?= verilator
TOP       ?= soc_sysctrl_tb
FILELIST  ?= soc_sysctrl.f
OBJ_DIR   ?= obj_dir
FLAGS     ?= --binary --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

# The testbench ends every failure in $$fatal, so the run step returns nonzero.
sim:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* soc_sysctrl.f */
src/pi1_pkg.sv
src/soc_map_pkg.sv
src/pi1_slave_if.sv
src/pi1_router.sv
src/devtbl_rom.sv
src/sysrst_ctrl.sv
src/soc_sysctrl.sv
tests/soc_sysctrl_properties.sv
tests/soc_sysctrl_tb.sv

/* src/devtbl_rom.sv */
`timescale 1ns/1ps

module devtbl_rom (
	input  logic       clk100mhz_i,
	pi1_slave_if.slave bus
);
	import pi1_pkg::*;
	import soc_map_pkg::*;

	logic [PI1_ADDR_W-1:0] offs;
	logic [PI1_DATA_W-1:0] tbl_word;
	logic [PI1_DATA_W-1:0] rdata_q;

	assign offs = bus.addr - PI1_ADDR_W'(DEVTBL_BASE);

	// Even words hold identifier and interrupt flag, odd words the map size.
	always_comb begin
		tbl_word = '0;
		if (offs < PI1_ADDR_W'(DEVTBL_WORDS)) begin
			for (int s = 0; s < SLOT_COUNT; s++) begin
				if (offs == PI1_ADDR_W'(2 * s)) begin
					tbl_word = {{(PI1_DATA_W - 17){1'b0}}, DEV_USEINTR[s], DEV_ID[s]};
				end else if (offs == PI1_ADDR_W'(2 * s + 1)) begin
					tbl_word = PI1_DATA_W'(DEV_MAPSZ[s]);
				end
			end
		end
	end

	// Words past the last slot stay zero.
	always_ff @(posedge clk100mhz_i) begin
		if (bus.op == PI1_RDOP || bus.op == PI1_RWOP) begin
			rdata_q <= tbl_word;
		end
	end

	assign bus.rdata = rdata_q;

	// The table never stalls.
	assign bus.rdy = 1'b1;

endmodule

/* src/pi1_pkg.sv */
package pi1_pkg;

	// Width of one data word on the interconnect.
	localparam int PI1_DATA_W = 32;

	// Addresses count whole data words.
	localparam int PI1_ADDR_W = 30;

	// One select bit per byte lane.
	localparam int PI1_SEL_W = PI1_DATA_W / 8;

	// Operation codes driven by the master.
	// A read-write returns the old value and stores the new one.
	typedef enum logic [1:0] {
		PI1_NOOP = 2'b00,
		PI1_WROP = 2'b01,
		PI1_RDOP = 2'b10,
		PI1_RWOP = 2'b11
	} pi1_op_e;

endpackage

/* src/pi1_router.sv */
`timescale 1ns/1ps

module pi1_router (
	input  logic                           clk100mhz_i,
	input  logic                           rst_p,
	input  pi1_pkg::pi1_op_e               pi1_op_i,
	input  logic [pi1_pkg::PI1_ADDR_W-1:0] pi1_addr_i,
	input  logic [pi1_pkg::PI1_DATA_W-1:0] pi1_data_i,
	input  logic [pi1_pkg::PI1_SEL_W-1:0]  pi1_sel_i,
	output logic [pi1_pkg::PI1_DATA_W-1:0] pi1_data_o,
	output logic                           pi1_rdy_o,
	pi1_slave_if.router                    devtbl_bus,
	pi1_slave_if.router                    rst_bus
);
	import pi1_pkg::*;
	import soc_map_pkg::*;

	typedef enum logic [1:0] {
		TGT_DEVTBL,
		TGT_RSTCTRL,
		TGT_INVALID
	} tgt_e;

	tgt_e                  tgt;
	tgt_e                  tgt_q;
	logic [PI1_ADDR_W-1:0] tbl_offs;
	logic                  accept;
	logic                  rd_q;
	logic [PI1_DATA_W-1:0] rsp;

	// Both slaves answer in one cycle, so ready only drops in reset.
	assign pi1_rdy_o = !rst_p && devtbl_bus.rdy && rst_bus.rdy;
	assign accept    = pi1_rdy_o && (pi1_op_i != PI1_NOOP);

	// Offset wraps for addresses below the base and fails the bound.
	assign tbl_offs = pi1_addr_i - PI1_ADDR_W'(DEVTBL_BASE);

	always_comb begin
		if (tbl_offs < PI1_ADDR_W'(DEVTBL_WORDS)) begin
			tgt = TGT_DEVTBL;
		end else if (pi1_addr_i == PI1_ADDR_W'(RSTCTRL_ADDR)) begin
			tgt = TGT_RSTCTRL;
		end else begin
			// Everything else lands on the invalid device.
			tgt = TGT_INVALID;
		end
	end

	// Only the addressed slave sees the operation.
	assign devtbl_bus.op    = (accept && tgt == TGT_DEVTBL) ? pi1_op_i : PI1_NOOP;
	assign devtbl_bus.addr  = pi1_addr_i;
	assign devtbl_bus.wdata = pi1_data_i;
	assign devtbl_bus.sel   = pi1_sel_i;

	assign rst_bus.op    = (accept && tgt == TGT_RSTCTRL) ? pi1_op_i : PI1_NOOP;
	assign rst_bus.addr  = pi1_addr_i;
	assign rst_bus.wdata = pi1_data_i;
	assign rst_bus.sel   = pi1_sel_i;

	// Remember who answers the access in flight.
	always_ff @(posedge clk100mhz_i) begin
		if (rst_p) begin
			tgt_q <= TGT_INVALID;
			rd_q  <= 1'b0;
		end else begin
			tgt_q <= accept ? tgt : TGT_INVALID;
			rd_q  <= accept && (pi1_op_i == PI1_RDOP || pi1_op_i == PI1_RWOP);
		end
	end

	always_comb begin
		case (tgt_q)
			TGT_DEVTBL:  rsp = devtbl_bus.rdata;
			TGT_RSTCTRL: rsp = rst_bus.rdata;
			// invalid device reads as zero
			default:     rsp = '0;
		endcase
	end

	// Writes and idle cycles return zero.
	assign pi1_data_o = rd_q ? rsp : '0;

endmodule

/* src/pi1_slave_if.sv */
`timescale 1ns/1ps

interface pi1_slave_if;
	import pi1_pkg::*;

	// Request side, driven by the router.
	pi1_op_e                 op;
	logic [PI1_ADDR_W-1:0]   addr;
	logic [PI1_DATA_W-1:0]   wdata;
	logic [PI1_SEL_W-1:0]    sel;

	// Response side, driven by the slave.
	logic [PI1_DATA_W-1:0]   rdata;
	logic                    rdy;

	modport router (
		output op,
		output addr,
		output wdata,
		output sel,
		input  rdata,
		input  rdy
	);

	modport slave (
		input  op,
		input  addr,
		input  wdata,
		input  sel,
		output rdata,
		output rdy
	);

endinterface

/* src/soc_map_pkg.sv */
package soc_map_pkg;

	// Slots in the order of the full SoC map.
	localparam int SLOT_SDCARD     = 0;
	localparam int SLOT_DEVTBL     = SLOT_SDCARD + 1;
	localparam int SLOT_GPIO       = SLOT_DEVTBL + 1;
	localparam int SLOT_DMA        = SLOT_GPIO + 1;
	localparam int SLOT_INTCTRL    = SLOT_DMA + 1;
	localparam int SLOT_UART       = SLOT_INTCTRL + 1;
	localparam int SLOT_RAM        = SLOT_UART + 1;
	localparam int SLOT_RAMCTRL    = SLOT_RAM + 1;
	localparam int SLOT_BOOTLDR    = SLOT_RAMCTRL + 1;
	localparam int SLOT_INVALIDDEV = SLOT_BOOTLDR + 1;
	localparam int SLOT_COUNT      = SLOT_INVALIDDEV + 1;

	// Device identifiers as seen by software.
	localparam logic [15:0] DEV_ID [SLOT_COUNT] = '{
		SLOT_SDCARD: 16'd4, SLOT_DEVTBL: 16'd7, SLOT_GPIO: 16'd6,
		SLOT_DMA: 16'd2, SLOT_INTCTRL: 16'd3, SLOT_UART: 16'd5,
		SLOT_RAM: 16'd1, default: 16'd0
	};

	// Map sizes in words.
	localparam int unsigned DEV_MAPSZ [SLOT_COUNT] = '{
		SLOT_SDCARD: 'h100, SLOT_DEVTBL: 'h20, SLOT_GPIO: 'h1,
		SLOT_DMA: 'h4, SLOT_INTCTRL: 'h1, SLOT_UART: 'h1,
		SLOT_RAM: 'h2000000, SLOT_RAMCTRL: 'h4000,
		SLOT_BOOTLDR: 'h400, SLOT_INVALIDDEV: 'h400
	};

	// Devices that raise interrupts.
	localparam bit DEV_USEINTR [SLOT_COUNT] = '{
		SLOT_SDCARD: 1'b1, SLOT_GPIO: 1'b1, SLOT_DMA: 1'b1,
		SLOT_UART: 1'b1, default: 1'b0
	};

	// The device table holds two words per slot and is padded to 32 words.
	localparam int DEVTBL_BASE  = 0;
	localparam int DEVTBL_WORDS = 32;

	// Software reset register, right after the table.
	localparam int RSTCTRL_ADDR = 32;

	// Reset hold length in clock cycles.
	localparam int RST_HOLD_CYCLES = 64;
	localparam int RST_CNTR_W      = 7;

endpackage

/* src/soc_sysctrl.sv */
`timescale 1ns/1ps

module soc_sysctrl (
	input  logic                           clk100mhz_i,
	input  logic                           rst_p,
	input  pi1_pkg::pi1_op_e               pi1_op_i,
	input  logic [pi1_pkg::PI1_ADDR_W-1:0] pi1_addr_i,
	input  logic [pi1_pkg::PI1_DATA_W-1:0] pi1_data_i,
	input  logic [pi1_pkg::PI1_SEL_W-1:0]  pi1_sel_i,
	output logic [pi1_pkg::PI1_DATA_W-1:0] pi1_data_o,
	output logic                           pi1_rdy_o,
	output logic                           sys_rst_o,
	output logic                           cold_rst_o,
	output logic                           pwroff_o
);
	import pi1_pkg::*;

	// One link per slave behind the router.
	pi1_slave_if devtbl_bus ();
	pi1_slave_if rst_bus ();

	pi1_router router (
		.clk100mhz_i (clk100mhz_i),
		.rst_p       (rst_p),
		.pi1_op_i    (pi1_op_i),
		.pi1_addr_i  (pi1_addr_i),
		.pi1_data_i  (pi1_data_i),
		.pi1_sel_i   (pi1_sel_i),
		.pi1_data_o  (pi1_data_o),
		.pi1_rdy_o   (pi1_rdy_o),
		.devtbl_bus  (devtbl_bus.router),
		.rst_bus     (rst_bus.router)
	);

	devtbl_rom devtbl (
		.clk100mhz_i (clk100mhz_i),
		.bus         (devtbl_bus.slave)
	);

	// The bus stays usable while sys_rst_o is high.
	sysrst_ctrl sysrst (
		.clk100mhz_i (clk100mhz_i),
		.rst_p       (rst_p),
		.bus         (rst_bus.slave),
		.sys_rst_o   (sys_rst_o),
		.cold_rst_o  (cold_rst_o),
		.pwroff_o    (pwroff_o)
	);

endmodule

/* src/sysrst_ctrl.sv */
`timescale 1ns/1ps

module sysrst_ctrl (
	input  logic       clk100mhz_i,
	input  logic       rst_p,
	pi1_slave_if.slave bus,
	output logic       sys_rst_o,
	output logic       cold_rst_o,
	output logic       pwroff_o
);
	import pi1_pkg::*;
	import soc_map_pkg::*;

	logic                  rst0_q;
	logic                  rst1_q;
	logic                  pwroff_q;
	logic [RST_CNTR_W-1:0] cntr_q;
	logic [PI1_DATA_W-1:0] rdata_q;
	logic                  wr;
	logic                  rd;
	logic                  sw_cold;
	logic                  sw_warm;
	logic                  sw_pwroff;

	// Only byte lane 0 carries the request bits.
	assign wr = (bus.op == PI1_WROP || bus.op == PI1_RWOP) && bus.sel[0];
	assign rd = (bus.op == PI1_RDOP || bus.op == PI1_RWOP);

	// Request decode from the two register bits.
	assign sw_cold   = rst0_q && rst1_q;
	assign sw_warm   = !rst0_q && rst1_q;
	assign sw_pwroff = rst0_q && !rst1_q;

	// Request bits live for a single cycle.
	always_ff @(posedge clk100mhz_i) begin
		if (rst_p) begin
			rst0_q <= 1'b0;
			rst1_q <= 1'b0;
		end else if (wr) begin
			rst0_q <= bus.wdata[0];
			rst1_q <= bus.wdata[1];
		end else begin
			rst0_q <= 1'b0;
			rst1_q <= 1'b0;
		end
	end

	// Power-off sticks until the external reset.
	always_ff @(posedge clk100mhz_i) begin
		if (rst_p) begin
			pwroff_q <= 1'b0;
		end else if (sw_pwroff) begin
			pwroff_q <= 1'b1;
		end
	end

	// Hold counter reloads on any reset source, then counts to zero.
	always_ff @(posedge clk100mhz_i) begin
		if (rst_p || sw_cold || sw_warm) begin
			cntr_q <= RST_CNTR_W'(RST_HOLD_CYCLES);
		end else if (cntr_q != '0) begin
			cntr_q <= cntr_q - 1'b1;
		end
	end

	// Sampled before the write lands, so read-write sees the old value.
	always_ff @(posedge clk100mhz_i) begin
		if (rd) begin
			rdata_q <= {{(PI1_DATA_W - 3){1'b0}}, pwroff_q, rst1_q, rst0_q};
		end
	end

	assign bus.rdata = rdata_q;
	assign bus.rdy   = 1'b1;

	assign cold_rst_o = sw_cold;
	assign pwroff_o   = pwroff_q;
	assign sys_rst_o  = (cntr_q != '0) || pwroff_q;

endmodule

/* tests/soc_sysctrl_properties.sv */
`timescale 1ns/1ps

module soc_sysctrl_properties (
	input logic clk100mhz_i,
	input logic rst_p,
	input logic pi1_rdy_o,
	input logic sys_rst_o,
	input logic cold_rst_o,
	input logic pwroff_o
);

	// A cold request is a single-cycle pulse.
	cold_pulse_a: assert property (
		@(posedge clk100mhz_i) disable iff (rst_p) cold_rst_o |=> !cold_rst_o
	) else $error("cold_rst_o held for more than one cycle");

	// Power-off keeps the system in reset.
	pwroff_hold_a: assert property (
		@(posedge clk100mhz_i) disable iff (rst_p) pwroff_o |-> sys_rst_o
	) else $error("pwroff_o high while sys_rst_o is low");

	assert property (@(posedge clk100mhz_i) rst_p |-> !pi1_rdy_o)
		else $error("pi1_rdy_o high during rst_p");

endmodule

bind soc_sysctrl soc_sysctrl_properties props (
	.clk100mhz_i (clk100mhz_i),
	.rst_p       (rst_p),
	.pi1_rdy_o   (pi1_rdy_o),
	.sys_rst_o   (sys_rst_o),
	.cold_rst_o  (cold_rst_o),
	.pwroff_o    (pwroff_o)
);

/* tests/soc_sysctrl_tb.sv */
`timescale 1ns/1ps

module soc_sysctrl_tb;
	import pi1_pkg::*;
	import soc_map_pkg::*;

	logic                  clk100mhz_i;
	logic                  rst_p;
	pi1_op_e               pi1_op_i;
	logic [PI1_ADDR_W-1:0] pi1_addr_i;
	logic [PI1_DATA_W-1:0] pi1_data_i;
	logic [PI1_SEL_W-1:0]  pi1_sel_i;
	logic [PI1_DATA_W-1:0] pi1_data_o;
	logic                  pi1_rdy_o;
	logic                  sys_rst_o;
	logic                  cold_rst_o;
	logic                  pwroff_o;

	integer seed;

	// Model of the reset register, the power-off latch and the hold counter.
	logic m_r0;
	logic m_r1;
	logic m_poff;
	int   m_cntr;

	soc_sysctrl DUT (.*);

	initial begin
		clk100mhz_i = 1'b0;
		forever #5 clk100mhz_i = ~clk100mhz_i;
	end

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("[ERROR] t=%0t %s: got 0x%08h, expected 0x%08h", $time, name, got, exp);
			$display("Verification failed");
			$fatal(1, "Value mismatch");
		end
	endtask

	// Even table words hold id and flag, odd words the map size.
	function automatic logic [31:0] expected_table_word(input int offs);
		int slot;
		slot = offs / 2;
		if (slot >= SLOT_COUNT) begin
			return 32'h0;
		end
		if (offs % 2 == 0) begin
			return {15'b0, DEV_USEINTR[slot], DEV_ID[slot]};
		end
		return DEV_MAPSZ[slot];
	endfunction

	function automatic logic [PI1_ADDR_W-1:0] unmapped_addr(input logic [31:0] r);
		logic [PI1_ADDR_W-1:0] a;
		a = r[PI1_ADDR_W-1:0];
		if (a <= 30'(RSTCTRL_ADDR)) begin
			a = a + 30'(RSTCTRL_ADDR + 1);
		end
		return a;
	endfunction

	// Drives one bus cycle at a falling edge and checks it at the next one.
	task automatic bus_cycle(input pi1_op_e op, input logic [PI1_ADDR_W-1:0] addr,
			input logic [PI1_DATA_W-1:0] data, input logic [PI1_SEL_W-1:0] sel);
		logic [PI1_DATA_W-1:0] exp_data;
		logic                  is_rd;
		logic                  is_wr;
		int                    a;
		a          = int'(addr);
		is_rd      = (op == PI1_RDOP) || (op == PI1_RWOP);
		is_wr      = (op == PI1_WROP) || (op == PI1_RWOP);
		pi1_op_i   = op;
		pi1_addr_i = addr;
		pi1_data_i = data;
		pi1_sel_i  = sel;
		exp_data   = '0;
		if (is_rd && a >= DEVTBL_BASE && a < DEVTBL_BASE + DEVTBL_WORDS) begin
			exp_data = expected_table_word(a - DEVTBL_BASE);
		end else if (is_rd && a == RSTCTRL_ADDR) begin
			exp_data = {29'b0, m_poff, m_r1, m_r0};
		end
		// Cold and warm both reload the hold. Rst0 alone latches power-off.
		if (m_r1) begin
			m_cntr = RST_HOLD_CYCLES;
		end else if (m_cntr > 0) begin
			m_cntr = m_cntr - 1;
		end
		if (m_r0 && !m_r1) begin
			m_poff = 1'b1;
		end
		if (is_wr && a == RSTCTRL_ADDR && sel[0]) begin
			m_r0 = data[0];
			m_r1 = data[1];
		end else begin
			m_r0 = 1'b0;
			m_r1 = 1'b0;
		end
		@(negedge clk100mhz_i);
		check_value("pi1_data_o", pi1_data_o, exp_data);
		check_value("pi1_rdy_o", 32'(pi1_rdy_o), 32'd1);
		check_value("sys_rst_o", 32'(sys_rst_o), 32'((m_cntr != 0) || m_poff));
		check_value("cold_rst_o", 32'(cold_rst_o), 32'(m_r0 && m_r1));
		check_value("pwroff_o", 32'(pwroff_o), 32'(m_poff));
	endtask

	task automatic apply_reset();
		rst_p    = 1'b1;
		pi1_op_i = PI1_NOOP;
		repeat (2) @(posedge clk100mhz_i);
		@(negedge clk100mhz_i);
		check_value("pi1_rdy_o", 32'(pi1_rdy_o), 32'd0);
		rst_p  = 1'b0;
		m_r0   = 1'b0;
		m_r1   = 1'b0;
		m_poff = 1'b0;
		m_cntr = RST_HOLD_CYCLES;
		check_value("sys_rst_o", 32'(sys_rst_o), 32'd1);
		check_value("cold_rst_o", 32'(cold_rst_o), 32'd0);
		check_value("pwroff_o", 32'(pwroff_o), 32'd0);
	endtask

	// Idles the bus and counts the cycles until sys_rst_o drops.
	task automatic count_hold(input int expected);
		int n;
		n = 0;
		while (sys_rst_o && n < 4 * RST_HOLD_CYCLES) begin
			bus_cycle(PI1_NOOP, '0, '0, '0);
			n++;
		end
		if (sys_rst_o) begin
			$display("Timeout: sys_rst_o stayed high");
			$display("Verification failed");
			$fatal(1, "Hold timeout");
		end
		check_value("sys_rst_o hold cycles", 32'(n), 32'(expected));
	endtask

	initial begin
		logic [31:0]           r;
		logic [31:0]           d;
		pi1_op_e               op;
		logic [PI1_ADDR_W-1:0] addr;
		logic                  rst_pick;
		logic                  rst_wr_last;
		seed        = 32'ha528_b56d;
		rst_p       = 1'b1;
		pi1_op_i    = PI1_NOOP;
		pi1_addr_i  = '0;
		pi1_data_i  = '0;
		pi1_sel_i   = '0;
		rst_wr_last = 1'b0;
		apply_reset();
		count_hold(RST_HOLD_CYCLES);

		// Table reads, writes and read-writes. Writes must not stick.
		repeat (80) begin
			r  = $random(seed);
			d  = $random(seed);
			op = pi1_op_e'(r[1:0]);
			if (op == PI1_NOOP) begin
				op = PI1_RDOP;
			end
			bus_cycle(op, 30'(r[8:4]), d, r[12:9]);
		end

		// Unmapped space.
		repeat (40) begin
			r  = $random(seed);
			d  = $random(seed);
			op = pi1_op_e'(r[1:0]);
			if (op == PI1_NOOP) begin
				op = PI1_WROP;
			end
			bus_cycle(op, unmapped_addr(d), r, d[3:0]);
		end

		// Warm request, then cold request.
		bus_cycle(PI1_WROP, 30'(RSTCTRL_ADDR), 32'h2, 4'h1);
		bus_cycle(PI1_NOOP, '0, '0, '0);
		count_hold(RST_HOLD_CYCLES);
		bus_cycle(PI1_WROP, 30'(RSTCTRL_ADDR), 32'h3, 4'h1);
		check_value("cold_rst_o", 32'(cold_rst_o), 32'd1);
		bus_cycle(PI1_NOOP, '0, '0, '0);
		count_hold(RST_HOLD_CYCLES);

		// Read-write sees the pending warm request, then clears it.
		bus_cycle(PI1_WROP, 30'(RSTCTRL_ADDR), 32'h2, 4'h1);
		bus_cycle(PI1_RWOP, 30'(RSTCTRL_ADDR), 32'h0, 4'h1);
		check_value("pi1_data_o", pi1_data_o, 32'h2);
		bus_cycle(PI1_RDOP, 30'(RSTCTRL_ADDR), 32'h0, 4'h0);
		// One hold cycle already went by during the read.
		count_hold(RST_HOLD_CYCLES - 1);

		// Power-off holds until the external reset.
		bus_cycle(PI1_WROP, 30'(RSTCTRL_ADDR), 32'h1, 4'h1);
		repeat (3 * RST_HOLD_CYCLES) begin
			bus_cycle(PI1_RDOP, 30'(RSTCTRL_ADDR), '0, '0);
		end
		check_value("pi1_data_o[2]", 32'(pi1_data_o[2]), 32'd1);
		apply_reset();
		count_hold(RST_HOLD_CYCLES);

		// Mixed traffic every cycle.
		repeat (500) begin
			r        = $random(seed);
			d        = $random(seed);
			op       = pi1_op_e'(r[1:0]);
			rst_pick = (r[3:2] == 2'd2) && !rst_wr_last;
			if (rst_pick) begin
				addr = 30'(RSTCTRL_ADDR);
			end else if (r[3]) begin
				addr = unmapped_addr(d);
			end else begin
				addr = 30'(r[8:4]);
			end
			// Register writes never come back to back, so a cold pulse stays one cycle.
			rst_wr_last = rst_pick && (op == PI1_WROP || op == PI1_RWOP);
			bus_cycle(op, addr, d, r[12:9]);
		end

		$display("Verification passed");
		$finish;
	end

endmodule
